/* verilog/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_WORD_WIDTH      32
`define CPU_REG_ADDR_WIDTH  5
`define CPU_IMEM_DEPTH      32
`define CPU_DMEM_DEPTH      16
`define CPU_IMEM_ADDR_WIDTH 5
`define CPU_DMEM_ADDR_WIDTH 4

// opcode field, bits 31:26
`define CPU_OP_RTYPE 6'h00
`define CPU_OP_ADDIU 6'h09
`define CPU_OP_LW    6'h23
`define CPU_OP_SW    6'h2b
`define CPU_OP_HALT  6'h3f

// funct field for r-type
`define CPU_FN_ADDU 6'h21
`define CPU_FN_SUBU 6'h23
`define CPU_FN_AND  6'h24
`define CPU_FN_OR   6'h25
`define CPU_FN_SLT  6'h2a

`endif

/* verilog/cpu_pkg.sv */
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0]      word_t;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0]  reg_idx_t;
    typedef logic [`CPU_IMEM_ADDR_WIDTH-1:0] imem_addr_t;

    // immediate is the low 16 bits, i.e. {rd, shamt, funct}
    typedef struct packed {
        logic [5:0] opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

endpackage

/* verilog/fetch_stage.sv */
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  logic       start,
    input  logic       stall,
    input  logic       halt_seen,
    input  logic       retire_done,
    output logic       id_valid,
    output instr_t     id_instr,
    output logic       busy
);

    word_t      imem [`CPU_IMEM_DEPTH];
    imem_addr_t pc;
    logic       running;
    logic       fetch_now;

    // nothing new enters once decode holds the halt
    assign fetch_now = running && !halt_seen;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            running  <= 1'b0;
            busy     <= 1'b0;
            id_valid <= 1'b0;
        end else begin
            if (start && !busy) begin
                pc      <= '0;
                running <= 1'b1;
                busy    <= 1'b1;
            end else if (retire_done) begin
                busy <= 1'b0;
            end
            if (halt_seen)
                running <= 1'b0;
            if (!stall) begin
                id_valid <= fetch_now;
                if (fetch_now)
                    pc <= pc + 1'b1;
            end
        end
    end

    // loader port, only while idle
    always_ff @(posedge clk_cpu) begin
        if (prog_we && !busy)
            imem[prog_addr] <= prog_data;
        if (!stall)
            id_instr <= instr_t'(imem[pc]);
    end

endmodule

/* verilog/decode_stage.sv */
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     id_valid,
    input  instr_t   id_instr,
    input  logic     stall,
    input  logic     wb_we,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output logic     halt_seen,
    output logic     ex_valid,
    output alu_op_t  ex_alu_op,
    output word_t    ex_a,
    output word_t    ex_b,
    output word_t    ex_store,
    output reg_idx_t ex_rs,
    output reg_idx_t ex_rt,
    output reg_idx_t ex_dest,
    output logic     ex_we,
    output logic     ex_load,
    output logic     ex_mem_write,
    output logic     ex_halt,
    output reg_idx_t id_rs,
    output reg_idx_t id_rt,
    output logic     id_uses_rt
);

    word_t    regs [1 << `CPU_REG_ADDR_WIDTH];
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_ext;
    alu_op_t  dec_op;
    reg_idx_t dec_dest;
    logic     dec_we;
    logic     dec_load;
    logic     dec_store;
    logic     dec_halt;
    logic     dec_imm;
    logic     uses_rt;
    logic     issue;

    // write-first, so a same-cycle write is seen by the read
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `CPU_REG_ADDR_WIDTH); i++)
                regs[i] <= '0;
        end else if (wb_we && wb_idx != '0) begin
            regs[wb_idx] <= wb_data;
        end
    end

    assign rs_val = (id_instr.rs == '0) ? '0 :
                    (wb_we && wb_idx == id_instr.rs) ? wb_data : regs[id_instr.rs];
    assign rt_val = (id_instr.rt == '0) ? '0 :
                    (wb_we && wb_idx == id_instr.rt) ? wb_data : regs[id_instr.rt];
    assign imm_ext = {{(`CPU_WORD_WIDTH - 16){id_instr[15]}}, id_instr[15:0]};

    always_comb begin
        dec_op    = ALU_ADD;
        dec_dest  = id_instr.rt;
        dec_we    = 1'b0;
        dec_load  = 1'b0;
        dec_store = 1'b0;
        dec_halt  = 1'b0;
        dec_imm   = 1'b1;
        uses_rt   = 1'b0;
        case (id_instr.opcode)
            `CPU_OP_RTYPE: begin
                dec_dest = id_instr.rd;
                dec_imm  = 1'b0;
                uses_rt  = 1'b1;
                dec_we   = 1'b1;
                case (id_instr.funct)
                    `CPU_FN_ADDU: dec_op = ALU_ADD;
                    `CPU_FN_SUBU: dec_op = ALU_SUB;
                    `CPU_FN_AND:  dec_op = ALU_AND;
                    `CPU_FN_OR:   dec_op = ALU_OR;
                    `CPU_FN_SLT:  dec_op = ALU_SLT;
                    default:      dec_we = 1'b0;
                endcase
            end
            `CPU_OP_ADDIU: dec_we = 1'b1;
            `CPU_OP_LW: begin
                dec_we   = 1'b1;
                dec_load = 1'b1;
            end
            `CPU_OP_SW: begin
                dec_store = 1'b1;
                uses_rt   = 1'b1;
            end
            `CPU_OP_HALT: dec_halt = 1'b1;
            default: ;
        endcase
    end

    assign issue      = id_valid && !stall;
    assign halt_seen  = issue && dec_halt;
    assign id_rs      = id_valid ? id_instr.rs : '0;
    assign id_rt      = id_instr.rt;
    assign id_uses_rt = id_valid && uses_rt;

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_we        <= 1'b0;
            ex_load      <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_halt      <= 1'b0;
        end else begin
            ex_valid     <= issue;
            ex_we        <= issue && dec_we;
            ex_load      <= issue && dec_load;
            ex_mem_write <= issue && dec_store;
            ex_halt      <= issue && dec_halt;
        end
    end

    // rt index is zeroed when rt is not read, which keeps it out of forwarding
    always_ff @(posedge clk_cpu) begin
        ex_alu_op <= dec_op;
        ex_a      <= rs_val;
        ex_b      <= dec_imm ? imm_ext : rt_val;
        ex_store  <= rt_val;
        ex_rs     <= id_instr.rs;
        ex_rt     <= uses_rt ? id_instr.rt : '0;
        ex_dest   <= dec_dest;
    end

endmodule

/* verilog/hazard_unit.sv */
module hazard_unit import cpu_pkg::*; (
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_uses_rt,
    input  logic     ex_valid,
    input  logic     ex_load,
    input  reg_idx_t ex_dest,
    output logic     stall
);

    logic load_in_ex;
    logic rs_hit;
    logic rt_hit;

    // a load in EX has no data until MEM, so its user waits a cycle
    assign load_in_ex = ex_valid && ex_load && ex_dest != '0;
    assign rs_hit     = ex_dest == id_rs;
    assign rt_hit     = id_uses_rt && ex_dest == id_rt;
    assign stall      = load_in_ex && (rs_hit || rt_hit);

endmodule

/* verilog/execute_stage.sv */
module execute_stage import cpu_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     ex_valid,
    input  alu_op_t  ex_alu_op,
    input  word_t    ex_a,
    input  word_t    ex_b,
    input  word_t    ex_store,
    input  reg_idx_t ex_rs,
    input  reg_idx_t ex_rt,
    input  reg_idx_t ex_dest,
    input  logic     ex_we,
    input  logic     ex_load,
    input  logic     ex_mem_write,
    input  logic     ex_halt,
    input  logic     wb_we,
    input  reg_idx_t wb_idx,
    input  word_t    wb_data,
    output logic     mem_valid,
    output logic     mem_we,
    output logic     mem_load,
    output logic     mem_write,
    output logic     mem_halt,
    output reg_idx_t mem_dest,
    output word_t    mem_result,
    output word_t    mem_store
);

    fwd_sel_t sel_a;
    fwd_sel_t sel_rt;
    word_t    op_a;
    word_t    rt_val;
    word_t    op_b;
    word_t    alu_y;

    // MEM wins over WB; load results never come from MEM
    function automatic fwd_sel_t pick_fwd(reg_idx_t src, logic m_we, logic m_load,
                                          reg_idx_t m_dest, logic w_we, reg_idx_t w_idx);
        if (src != '0 && m_we && !m_load && m_dest == src)
            return FWD_MEM;
        else if (src != '0 && w_we && w_idx == src)
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    assign sel_a  = pick_fwd(ex_rs, mem_we, mem_load, mem_dest, wb_we, wb_idx);
    assign sel_rt = pick_fwd(ex_rt, mem_we, mem_load, mem_dest, wb_we, wb_idx);

    always_comb begin
        case (sel_a)
            FWD_MEM: op_a = mem_result;
            FWD_WB:  op_a = wb_data;
            default: op_a = ex_a;
        endcase
        case (sel_rt)
            FWD_MEM: rt_val = mem_result;
            FWD_WB:  rt_val = wb_data;
            default: rt_val = ex_store;
        endcase
        // sw keeps its immediate as b
        op_b = (!ex_mem_write && sel_rt != FWD_REG) ? rt_val : ex_b;
    end

    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = word_t'($signed(op_a) < $signed(op_b));
            default: alu_y = op_a + op_b;
        endcase
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
            mem_we    <= 1'b0;
            mem_load  <= 1'b0;
            mem_write <= 1'b0;
            mem_halt  <= 1'b0;
        end else begin
            mem_valid <= ex_valid;
            mem_we    <= ex_we;
            mem_load  <= ex_load;
            mem_write <= ex_mem_write;
            mem_halt  <= ex_halt;
        end
    end

    always_ff @(posedge clk_cpu) begin
        mem_dest   <= ex_dest;
        mem_result <= alu_y;
        mem_store  <= rt_val;
    end

endmodule

/* verilog/memory_writeback.sv */
`include "cpu_cfg.svh"

module memory_writeback import cpu_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     mem_valid,
    input  logic     mem_we,
    input  logic     mem_load,
    input  logic     mem_write,
    input  logic     mem_halt,
    input  reg_idx_t mem_dest,
    input  word_t    mem_result,
    input  word_t    mem_store,
    output logic     wb_we,
    output reg_idx_t wb_idx,
    output word_t    wb_data,
    output logic     wb_valid,
    output logic     done
);

    word_t                          dmem [`CPU_DMEM_DEPTH];
    logic [`CPU_DMEM_ADDR_WIDTH-1:0] daddr;
    word_t                          rd_word;
    logic                           wb_item;
    logic                           wb_we_q;
    logic                           wb_load;
    logic                           wb_halt;
    word_t                          wb_result;
    word_t                          wb_rd_word;

    // word address from byte address
    assign daddr   = mem_result[`CPU_DMEM_ADDR_WIDTH+1:2];
    assign rd_word = dmem[daddr];

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++)
                dmem[i] <= '0;
        end else if (mem_valid && mem_write) begin
            dmem[daddr] <= mem_store;
        end
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            wb_item <= 1'b0;
            wb_we_q <= 1'b0;
            wb_load <= 1'b0;
            wb_halt <= 1'b0;
        end else begin
            wb_item <= mem_valid;
            wb_we_q <= mem_we;
            wb_load <= mem_load;
            wb_halt <= mem_halt;
        end
    end

    always_ff @(posedge clk_cpu) begin
        wb_idx     <= mem_dest;
        wb_result  <= mem_result;
        wb_rd_word <= rd_word;
    end

    assign wb_we    = wb_item && wb_we_q;
    assign wb_data  = wb_load ? wb_rd_word : wb_result;
    // r0 writes retire silently
    assign wb_valid = wb_we && wb_idx != '0;
    assign done     = wb_item && wb_halt;

endmodule

/* verilog/pipeline_cpu.sv */
module pipeline_cpu import cpu_pkg::*; (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  logic       start,
    output logic       busy,
    output logic       wb_valid,
    output reg_idx_t   wb_idx,
    output word_t      wb_data,
    output logic       done
);

    logic     stall;
    logic     halt_seen;
    logic     id_valid;
    instr_t   id_instr;
    reg_idx_t id_rs;
    reg_idx_t id_rt;
    logic     id_uses_rt;

    logic     ex_valid;
    alu_op_t  ex_alu_op;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_store;
    reg_idx_t ex_rs;
    reg_idx_t ex_rt;
    reg_idx_t ex_dest;
    logic     ex_we;
    logic     ex_load;
    logic     ex_mem_write;
    logic     ex_halt;

    logic     mem_valid;
    logic     mem_we;
    logic     mem_load;
    logic     mem_write;
    logic     mem_halt;
    reg_idx_t mem_dest;
    word_t    mem_result;
    word_t    mem_store;

    logic     wb_we;

    fetch_stage fetch_stage_i (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .start       (start),
        .stall       (stall),
        .halt_seen   (halt_seen),
        .retire_done (done),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .busy        (busy)
    );

    decode_stage decode_stage_i (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .id_valid     (id_valid),
        .id_instr     (id_instr),
        .stall        (stall),
        .wb_we        (wb_we),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .halt_seen    (halt_seen),
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_store     (ex_store),
        .ex_rs        (ex_rs),
        .ex_rt        (ex_rt),
        .ex_dest      (ex_dest),
        .ex_we        (ex_we),
        .ex_load      (ex_load),
        .ex_mem_write (ex_mem_write),
        .ex_halt      (ex_halt),
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .id_uses_rt   (id_uses_rt)
    );

    hazard_unit hazard_unit_i (
        .id_rs      (id_rs),
        .id_rt      (id_rt),
        .id_uses_rt (id_uses_rt),
        .ex_valid   (ex_valid),
        .ex_load    (ex_load),
        .ex_dest    (ex_dest),
        .stall      (stall)
    );

    execute_stage execute_stage_i (
        .clk_cpu      (clk_cpu),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_alu_op    (ex_alu_op),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_store     (ex_store),
        .ex_rs        (ex_rs),
        .ex_rt        (ex_rt),
        .ex_dest      (ex_dest),
        .ex_we        (ex_we),
        .ex_load      (ex_load),
        .ex_mem_write (ex_mem_write),
        .ex_halt      (ex_halt),
        .wb_we        (wb_we),
        .wb_idx       (wb_idx),
        .wb_data      (wb_data),
        .mem_valid    (mem_valid),
        .mem_we       (mem_we),
        .mem_load     (mem_load),
        .mem_write    (mem_write),
        .mem_halt     (mem_halt),
        .mem_dest     (mem_dest),
        .mem_result   (mem_result),
        .mem_store    (mem_store)
    );

    memory_writeback memory_writeback_i (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .mem_we     (mem_we),
        .mem_load   (mem_load),
        .mem_write  (mem_write),
        .mem_halt   (mem_halt),
        .mem_dest   (mem_dest),
        .mem_result (mem_result),
        .mem_store  (mem_store),
        .wb_we      (wb_we),
        .wb_idx     (wb_idx),
        .wb_data    (wb_data),
        .wb_valid   (wb_valid),
        .done       (done)
    );

endmodule

/* tb/pipeline_cpu_checker.sv */
module pipeline_cpu_checker import cpu_pkg::*; (
    input logic     clk_cpu,
    input logic     rst_n,
    input logic     busy,
    input logic     wb_valid,
    input reg_idx_t wb_idx,
    input logic     done
);

    int assert_errors = 0;

    quiet_in_reset: assert property (@(posedge clk_cpu) !rst_n |-> !wb_valid && !done)
        else begin
            assert_errors++;
            $error("wb_valid or done high while reset is asserted");
        end

    done_one_cycle: assert property (@(posedge clk_cpu) disable iff (!rst_n) done |=> !done)
        else begin
            assert_errors++;
            $error("done held high for more than one cycle");
        end

    // busy is cleared by the retiring halt
    busy_after_done: assert property (@(posedge clk_cpu) disable iff (!rst_n) done |=> !busy)
        else begin
            assert_errors++;
            $error("busy still high in the cycle after done");
        end

    no_r0_strobe: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        wb_valid |-> wb_idx != '0)
        else begin
            assert_errors++;
            $error("write-back strobe shows register 0");
        end

endmodule

bind pipeline_cpu pipeline_cpu_checker pipeline_cpu_checker_i (
    .clk_cpu  (clk_cpu),
    .rst_n    (rst_n),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_idx   (wb_idx),
    .done     (done)
);

/* tb/pipeline_cpu_monitor.sv */
module pipeline_cpu_monitor import cpu_pkg::*; (
    input logic     clk_cpu,
    input logic     rst_n,
    input logic     start,
    input logic     busy,
    input logic     wb_valid,
    input reg_idx_t wb_idx,
    input word_t    wb_data,
    input logic     done
);

    reg_idx_t exp_idx [$];
    word_t    exp_val [$];
    string    test_name = "";
    string    fail_line = "";
    int       seen = 0;
    bit       in_run = 1'b0;
    int       pass_count = 0;
    int       fail_count = 0;

    task automatic begin_test(string name);
        test_name = name;
        fail_line = "";
        seen = 0;
        exp_idx.delete();
        exp_val.delete();
    endtask

    task automatic expect_wb(reg_idx_t idx, word_t val);
        exp_idx.push_back(idx);
        exp_val.push_back(val);
    endtask

    // keep the first failure of a test only
    function automatic void note_failure(string line);
        if (fail_line == "")
            fail_line = line;
    endfunction

    // sampled mid-cycle away from the driving edge
    always @(negedge clk_cpu) begin
        if (rst_n) begin
            if (in_run && !busy)
                note_failure($sformatf("busy went low before done in test %s", test_name));
            if (start)
                in_run = 1'b1;
            if (wb_valid) begin
                seen++;
                if (exp_idx.size() == 0) begin
                    note_failure($sformatf("extra write-back r%0d=%08h in test %s",
                                           wb_idx, wb_data, test_name));
                end else begin
                    if (wb_idx !== exp_idx[0] || wb_data !== exp_val[0])
                        note_failure($sformatf(
                            "mismatch in %s: expected r%0d=%08h, actual r%0d=%08h",
                            test_name, exp_idx[0], exp_val[0], wb_idx, wb_data));
                    void'(exp_idx.pop_front());
                    void'(exp_val.pop_front());
                end
            end
            if (done) begin
                in_run = 1'b0;
                if (exp_idx.size() != 0)
                    note_failure($sformatf("%0d write-backs missing at done in test %s",
                                           exp_idx.size(), test_name));
                if (fail_line == "") begin
                    pass_count++;
                    $display("ok   %s: %0d write-backs", test_name, seen);
                end else begin
                    fail_count++;
                    $display("%s", fail_line);
                end
            end
        end
    end

endmodule

/* tb/pipeline_cpu_tb.sv */
`include "cpu_cfg.svh"

module pipeline_cpu_tb import cpu_pkg::*; ();

    logic       clk_cpu;
    logic       rst_n;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    logic       start;
    logic       busy;
    logic       wb_valid;
    reg_idx_t   wb_idx;
    word_t      wb_data;
    logic       done;

    word_t prog_words [$];
    int    test_first [$];
    int    test_len [$];
    string test_names [$];
    int    open_first = 0;
    word_t model_regs [32];
    word_t model_dmem [`CPU_DMEM_DEPTH];
    int    limit_cycles = 0;

    pipeline_cpu pipeline_cpu_i (
        .clk_cpu   (clk_cpu),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .busy      (busy),
        .wb_valid  (wb_valid),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data),
        .done      (done)
    );

    pipeline_cpu_monitor pipeline_cpu_monitor_i (
        .clk_cpu  (clk_cpu),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (busy),
        .wb_valid (wb_valid),
        .wb_idx   (wb_idx),
        .wb_data  (wb_data),
        .done     (done)
    );

    initial begin
        clk_cpu = 1'b0;
        forever #5 clk_cpu = ~clk_cpu;
    end

    // small assembler, one task per instruction form
    task automatic rop(logic [5:0] fn, int rd, int rs, int rt);
        prog_words.push_back({`CPU_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn});
    endtask

    task automatic addiu(int rt, int rs, int imm);
        prog_words.push_back({`CPU_OP_ADDIU, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    task automatic lw(int rt, int off, int base);
        prog_words.push_back({`CPU_OP_LW, base[4:0], rt[4:0], off[15:0]});
    endtask

    task automatic sw(int rt, int off, int base);
        prog_words.push_back({`CPU_OP_SW, base[4:0], rt[4:0], off[15:0]});
    endtask

    task automatic halt_test(string name);
        prog_words.push_back({`CPU_OP_HALT, 26'd0});
        test_first.push_back(open_first);
        test_len.push_back(prog_words.size() - open_first);
        test_names.push_back(name);
        open_first = prog_words.size();
    endtask

    task automatic build_tests();
        addiu(1, 0, 12);
        addiu(2, 0, 10);
        rop(`CPU_FN_ADDU, 3, 1, 2);
        rop(`CPU_FN_SUBU, 4, 3, 1);
        rop(`CPU_FN_AND, 5, 4, 3);
        rop(`CPU_FN_OR, 6, 5, 4);
        rop(`CPU_FN_SLT, 7, 6, 3);
        halt_test("alu_chain");
        addiu(1, 0, 5);
        addiu(8, 0, -7);
        addiu(9, 8, -100);
        rop(`CPU_FN_SLT, 10, 9, 8);
        rop(`CPU_FN_SLT, 11, 8, 1);
        rop(`CPU_FN_SLT, 12, 1, 8);
        rop(`CPU_FN_SUBU, 13, 8, 1);
        halt_test("sign_extend");
        addiu(1, 0, 'h11);
        addiu(2, 0, 'h22);
        addiu(14, 0, 8);
        sw(1, 0, 0);
        lw(3, 0, 0);
        sw(2, 4, 14);
        lw(4, -4, 14);
        lw(5, 12, 0);
        halt_test("store_load");
        addiu(1, 0, 40);
        sw(1, 16, 0);
        lw(2, 16, 0);
        rop(`CPU_FN_ADDU, 3, 2, 2);
        lw(4, 16, 0);
        addiu(5, 0, 1);
        rop(`CPU_FN_SUBU, 6, 4, 5);
        lw(7, 16, 0);
        sw(7, 20, 0);
        lw(8, 20, 0);
        rop(`CPU_FN_OR, 9, 8, 5);
        halt_test("load_use");
        addiu(1, 0, 9);
        addiu(0, 0, 55);
        rop(`CPU_FN_ADDU, 0, 1, 1);
        rop(`CPU_FN_ADDU, 10, 0, 1);
        lw(0, 16, 0);
        rop(`CPU_FN_OR, 11, 0, 0);
        halt_test("r0_writes");
        addiu(1, 0, -1);
        rop(`CPU_FN_ADDU, 2, 1, 1);
        rop(`CPU_FN_AND, 3, 2, 1);
        rop(`CPU_FN_SLT, 4, 1, 0);
        halt_test("rerun");
    endtask

    task automatic retire(logic [4:0] idx, word_t val);
        if (idx != 5'd0) begin
            model_regs[idx] = val;
            pipeline_cpu_monitor_i.expect_wb(idx, val);
        end
    endtask

    // one instruction at a time, straight from the ISA rules
    task automatic run_model(int first, int len);
        word_t w;
        word_t a;
        word_t b;
        word_t imm;
        word_t res;
        word_t addr;
        for (int pc = 0; pc < len; pc++) begin
            w = prog_words[first + pc];
            if (w[31:26] == `CPU_OP_HALT)
                break;
            a = model_regs[w[25:21]];
            b = model_regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            case (w[31:26])
                `CPU_OP_RTYPE: begin
                    case (w[5:0])
                        `CPU_FN_ADDU: res = a + b;
                        `CPU_FN_SUBU: res = a - b;
                        `CPU_FN_AND:  res = a & b;
                        `CPU_FN_OR:   res = a | b;
                        default:      res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                    retire(w[15:11], res);
                end
                `CPU_OP_ADDIU: retire(w[20:16], addr);
                `CPU_OP_LW:    retire(w[20:16], model_dmem[addr[`CPU_DMEM_ADDR_WIDTH+1:2]]);
                `CPU_OP_SW:    model_dmem[addr[`CPU_DMEM_ADDR_WIDTH+1:2]] = b;
                default: ;
            endcase
        end
    endtask

    task automatic load_program(int first, int len);
        for (int i = 0; i < len; i++) begin
            @(posedge clk_cpu);
            #1;
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(i);
            prog_data = prog_words[first + i];
        end
        @(posedge clk_cpu);
        #1;
        prog_we = 1'b0;
    endtask

    task automatic run_until_done();
        start = 1'b1;
        @(posedge clk_cpu);
        #1;
        start = 1'b0;
        while (!done) begin
            @(posedge clk_cpu);
            #1;
        end
        // let the monitor finish the test first
        @(posedge clk_cpu);
        #1;
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_cpu);
        $display("timeout: done did not arrive within %0d cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main_flow
        int total;
        int asserts;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        start     = 1'b0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        foreach (model_dmem[i])
            model_dmem[i] = '0;
        build_tests();
        total = 16;
        foreach (test_len[t])
            total += test_len[t] * 3 + 40;
        limit_cycles = total;
        repeat (16) @(posedge clk_cpu);
        #1;
        rst_n = 1'b1;
        foreach (test_names[t]) begin
            pipeline_cpu_monitor_i.begin_test(test_names[t]);
            run_model(test_first[t], test_len[t]);
            load_program(test_first[t], test_len[t]);
            run_until_done();
        end
        asserts = pipeline_cpu_i.pipeline_cpu_checker_i.assert_errors;
        $display("summary: %0d passed, %0d failed, %0d assertion errors",
                 pipeline_cpu_monitor_i.pass_count, pipeline_cpu_monitor_i.fail_count, asserts);
        if (pipeline_cpu_monitor_i.fail_count == 0 && asserts == 0 &&
            pipeline_cpu_monitor_i.pass_count == test_names.size()) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* pipeline_cpu.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/pipeline_cpu.sv
tb/pipeline_cpu_checker.sv
tb/pipeline_cpu_monitor.sv
tb/pipeline_cpu_tb.sv
